/* bench/debug_unit_assert.sv */
`timescale 1ns/1ps

module debug_unit_assert (
    input logic             clk,
    input logic             i_rst_n,
    input logic             i_tx_start,
    input logic             i_tx_done,
    input logic             i_valid,
    input logic             i_step,
    input debug_pkg::mode_e i_mode
);

    logic tx_wait_q;                                             // Set by a start and cleared by its done

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_wait_q <= 1'b0;
        end else if (i_tx_start) begin
            tx_wait_q <= 1'b1;
        end else if (i_tx_done) begin
            tx_wait_q <= 1'b0;
        end
    end

    a_tx_start_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx_start |=> !i_tx_start)
        else $error("o_tx_start stayed high for more than one cycle");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_valid |=> !i_valid)
        else $error("o_valid stayed high for more than one cycle");

    a_tx_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx_start |-> !tx_wait_q)
        else $error("o_tx_start came before i_tx_done of the previous byte");

    a_no_step_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mode == debug_pkg::MODE_IDLE) |-> !i_step)
        else $error("o_step high while the controller is idle");

endmodule

bind debug_unit debug_unit_assert u_debug_unit_assert (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_tx_start (o_tx_start),
    .i_tx_done  (i_tx_done),
    .i_valid    (o_valid),
    .i_step     (o_step),
    .i_mode     (u_debug_ctrl.mode_q)
);

/* bench/debug_unit_tb.sv */
`timescale 1ns/1ps

module debug_unit_tb;

    localparam int RX_GAP         = 2;                           // Idle cycles after a received byte
    localparam int MAX_GAP        = 8;                           // Slowest transmitter answer
    localparam int SETTLE         = MAX_GAP + 4;
    localparam int LOAD_WORDS     = 3;
    localparam int TIMEOUT_CYCLES = 20000;                       // Five dumps of 360 cycles plus loads

    logic                                clk;
    logic                                i_rst_n;
    debug_pkg::byte_t                    i_rx;
    logic                                i_rx_done;
    logic                                i_tx_done;
    logic                                i_end;
    logic [debug_pkg::NB_ID_EX-1:0]      i_seg_id_ex;
    logic [debug_pkg::NB_EX_MEM-1:0]     i_seg_ex_mem;
    logic [debug_pkg::NB_MEM_WB-1:0]     i_seg_mem_wb;
    logic [debug_pkg::NB_WB_ID-1:0]      i_seg_wb_id;
    logic [debug_pkg::NB_CONTROL-1:0]    i_ctrl_id_ex;
    logic                                o_tx_start;
    debug_pkg::byte_t                    o_data;
    debug_pkg::word_t                    o_instruction;
    debug_pkg::word_t                    o_instruction_address;
    logic                                o_valid;
    logic                                o_step;
    logic                                o_start;

    logic [31:0]      data_lfsr;
    logic [31:0]      gap_lfsr;
    logic             long_gaps;                                 // Transmitter always takes MAX_GAP
    int               error_cnt;
    int               check_cnt;
    int               test_cnt;
    int               step_cnt;                                  // Cycles with o_step high
    int               start_high_cnt;
    int               start_low_cnt;
    debug_pkg::byte_t tx_bytes[$];
    debug_pkg::word_t valid_words[$];
    debug_pkg::word_t valid_addrs[$];

    debug_unit i_debug_unit (
        .clk                   (clk),
        .i_rst_n               (i_rst_n),
        .i_rx                  (i_rx),
        .i_rx_done             (i_rx_done),
        .i_tx_done             (i_tx_done),
        .i_end                 (i_end),
        .i_seg_id_ex           (i_seg_id_ex),
        .i_seg_ex_mem          (i_seg_ex_mem),
        .i_seg_mem_wb          (i_seg_mem_wb),
        .i_seg_wb_id           (i_seg_wb_id),
        .i_ctrl_id_ex          (i_ctrl_id_ex),
        .o_tx_start            (o_tx_start),
        .o_data                (o_data),
        .o_instruction         (o_instruction),
        .o_instruction_address (o_instruction_address),
        .o_valid               (o_valid),
        .o_step                (o_step),
        .o_start               (o_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int nbits, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};                      // One step per bit
        end
    endtask

    // Transmitter model answers each start after 1 to 8 cycles
    initial begin
        int          wait_cnt;
        logic [31:0] bits;
        i_tx_done = 1'b0;
        wait_cnt  = 0;
        gap_lfsr  = 32'h93b9;
        forever begin
            @(posedge clk);
            #1;
            i_tx_done = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    i_tx_done = 1'b1;
                end
            end else if (o_tx_start) begin
                tx_bytes.push_back(o_data);
                draw_bits(gap_lfsr, 3, bits);
                wait_cnt = long_gaps ? MAX_GAP : int'(bits) + 1;
            end
        end
    end

    // Mid-cycle sampling of the DUT levels and strobes
    always @(negedge clk) begin
        if (o_valid) begin
            valid_words.push_back(o_instruction);
            valid_addrs.push_back(o_instruction_address);
        end
        if (o_step) begin
            step_cnt++;
        end
        if (o_start) begin
            start_high_cnt++;
        end else begin
            start_low_cnt++;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input debug_pkg::word_t got, input debug_pkg::word_t exp,
                              input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input debug_pkg::byte_t got, input debug_pkg::byte_t exp,
                              input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic send_byte(input debug_pkg::byte_t b);
        i_rx      = b;
        i_rx_done = 1'b1;
        next_cycle();
        i_rx_done = 1'b0;
        repeat (RX_GAP) next_cycle();
    endtask

    task automatic send_word(input debug_pkg::word_t w);
        for (int i = 0; i < debug_pkg::WORD_BYTES; i++) begin
            send_byte(w[debug_pkg::NB_WORD-1 -: debug_pkg::NB_BYTE]);  // Most significant first
            w = w << debug_pkg::NB_BYTE;
        end
    endtask

    task automatic random_word(output debug_pkg::word_t w);
        logic [31:0] bits;
        draw_bits(data_lfsr, 32, bits);
        w = bits;
    endtask

    task automatic random_dump(output debug_pkg::dump_t d);
        logic [31:0] bits;
        d = '0;
        repeat (debug_pkg::NB_DUMP / 32) begin
            draw_bits(data_lfsr, 32, bits);
            d = (d << 32) | debug_pkg::dump_t'(bits);
        end
    endtask

    // ID/EX on top, control register at the bottom
    task automatic set_segments(input debug_pkg::dump_t d);
        {i_seg_id_ex, i_seg_ex_mem, i_seg_mem_wb, i_seg_wb_id, i_ctrl_id_ex} = d;
    endtask

    task automatic clear_records();
        tx_bytes.delete();
        valid_words.delete();
        valid_addrs.delete();
        step_cnt       = 0;
        start_high_cnt = 0;
        start_low_cnt  = 0;
    endtask

    task automatic expect_dump(input debug_pkg::dump_t exp, input string what);
        debug_pkg::dump_t rest;
        while (tx_bytes.size() < debug_pkg::DUMP_BYTES) next_cycle();
        repeat (SETTLE) next_cycle();                            // Catch any extra byte
        check_count(tx_bytes.size(), debug_pkg::DUMP_BYTES, {what, " byte count"});
        rest = exp;
        for (int i = 0; i < debug_pkg::DUMP_BYTES; i++) begin
            check_byte(tx_bytes[i], rest[debug_pkg::NB_DUMP-1 -: debug_pkg::NB_BYTE],
                       $sformatf("%s byte %0d", what, i));
            rest = rest << debug_pkg::NB_BYTE;
        end
    endtask

    // Free run until i_end and swap the segments once d is captured
    task automatic run_continuous(input debug_pkg::dump_t d);
        debug_pkg::dump_t other;
        send_byte(debug_pkg::CMD_CONTINUOUS);
        repeat (10) begin
            check_bit(o_step, 1'b1, "o_step while running");
            check_bit(o_start, 1'b1, "o_start while running");
            next_cycle();
        end
        set_segments(d);
        i_end = 1'b1;
        next_cycle();
        next_cycle();
        random_dump(other);
        set_segments(other);
        i_end = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("%s: finished with %0d errors", name, error_cnt - errs_before);
    endtask

    task automatic program_load();
        debug_pkg::word_t words[$];
        debug_pkg::word_t w;
        int               errs;
        errs = error_cnt;
        clear_records();
        for (int i = 0; i < LOAD_WORDS; i++) begin
            random_word(w);
            if (w == debug_pkg::HALT_INSTR) begin
                w[0] = 1'b0;
            end
            words.push_back(w);
        end
        words.push_back(debug_pkg::HALT_INSTR);
        send_byte(debug_pkg::CMD_LOAD);
        foreach (words[i]) send_word(words[i]);
        while (valid_words.size() < words.size()) next_cycle();
        repeat (SETTLE) next_cycle();
        check_count(valid_words.size(), words.size(), "o_valid strobes");
        foreach (words[i]) begin
            check_word(valid_words[i], words[i], $sformatf("word %0d", i));
            check_word(valid_addrs[i], debug_pkg::INSTR_STEP * debug_pkg::word_t'(i),
                       $sformatf("address of word %0d", i));
        end
        check_count(start_high_cnt, 0, "cycles with o_start high during load");
        check_bit(o_start, 1'b0, "o_start after load");
        finish_test("program_load", errs);
    endtask

    task automatic ignored_commands();
        debug_pkg::byte_t junk[5];
        int               errs;
        errs = error_cnt;
        junk = '{8'h00, debug_pkg::CMD_STEP, debug_pkg::CMD_END_DEBUG, 8'h55, 8'hff};
        clear_records();
        foreach (junk[i]) send_byte(junk[i]);
        repeat (SETTLE) next_cycle();
        check_count(valid_words.size(), 0, "o_valid strobes in idle");
        check_count(step_cnt, 0, "o_step cycles in idle");
        check_count(start_high_cnt, 0, "o_start cycles in idle");
        check_count(tx_bytes.size(), 0, "bytes sent in idle");
        finish_test("ignored_commands", errs);
    endtask

    task automatic continuous_run();
        debug_pkg::dump_t d;
        int               errs;
        errs = error_cnt;
        random_dump(d);
        clear_records();
        run_continuous(d);
        expect_dump(d, "continuous dump");
        check_bit(o_start, 1'b0, "o_start after continuous run");
        check_bit(o_step, 1'b0, "o_step after continuous run");
        finish_test("continuous_run", errs);
    endtask

    task automatic debug_stepping();
        debug_pkg::dump_t d;
        debug_pkg::dump_t other;
        int               errs;
        errs = error_cnt;
        send_byte(debug_pkg::CMD_DEBUG);
        clear_records();
        for (int k = 0; k < 2; k++) begin
            random_dump(d);
            set_segments(d);
            tx_bytes.delete();
            send_byte(debug_pkg::CMD_STEP);
            random_dump(other);
            set_segments(other);                                 // Snapshot must not follow this
            expect_dump(d, $sformatf("step %0d dump", k));
            check_count(step_cnt, k + 1, "o_step cycles");
            check_bit(o_start, 1'b1, "o_start between steps");
        end
        check_count(start_low_cnt, 0, "cycles with o_start low while debugging");
        finish_test("debug_stepping", errs);
    endtask

    task automatic end_of_debug();
        debug_pkg::dump_t d;
        debug_pkg::dump_t other;
        int               errs;
        errs = error_cnt;
        random_dump(d);
        clear_records();
        set_segments(d);
        send_byte(debug_pkg::CMD_END_DEBUG);
        random_dump(other);
        set_segments(other);
        expect_dump(d, "final dump");
        check_count(step_cnt, 0, "o_step cycles at end of debug");
        check_bit(o_start, 1'b0, "o_start after end of debug");
        valid_words.delete();
        valid_addrs.delete();
        send_byte(debug_pkg::CMD_LOAD);
        send_word(debug_pkg::HALT_INSTR);
        while (valid_words.size() < 1) next_cycle();
        repeat (SETTLE) next_cycle();
        check_count(valid_words.size(), 1, "o_valid strobes on reload");
        check_word(valid_words[0], debug_pkg::HALT_INSTR, "reloaded word");
        check_word(valid_addrs[0], '0, "reloaded address");
        check_bit(o_start, 1'b0, "o_start after reload");
        finish_test("end_of_debug", errs);
    endtask

    task automatic back_pressure();
        debug_pkg::dump_t d;
        int               errs;
        errs      = error_cnt;
        long_gaps = 1'b1;
        random_dump(d);
        clear_records();
        run_continuous(d);
        expect_dump(d, "slow dump");
        long_gaps = 1'b0;
        check_bit(o_start, 1'b0, "o_start after slow dump");
        finish_test("back_pressure", errs);
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_rx      = '0;
        i_rx_done = 1'b0;
        i_end     = 1'b0;
        long_gaps = 1'b0;
        data_lfsr = 32'h93b9;
        error_cnt = 0;
        check_cnt = 0;
        test_cnt  = 0;
        set_segments('0);
        repeat (4) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        next_cycle();
        check_bit(o_tx_start, 1'b0, "o_tx_start after reset");
        check_bit(o_valid, 1'b0, "o_valid after reset");
        check_bit(o_step, 1'b0, "o_step after reset");
        check_bit(o_start, 1'b0, "o_start after reset");
        program_load();
        ignored_commands();
        continuous_run();
        debug_stepping();
        end_of_debug();
        back_pressure();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* design/debug_ctrl.sv */
`timescale 1ns/1ps

module debug_ctrl (
    input  logic             clk,
    input  logic             i_rst_n,
    input  debug_pkg::byte_t i_rx,
    input  logic             i_rx_done,
    input  logic             i_end,
    input  logic             i_halt_seen,
    input  logic             i_dump_done,
    output logic             o_load_en,
    output logic             o_dump_req,
    output logic             o_step,
    output logic             o_start
);

    debug_pkg::mode_e mode_q;
    debug_pkg::mode_e mode_next;
    logic             ret_debug_q;                               // Where to go after the dump
    logic             ret_debug_next;
    logic             step_q;                                    // Single step pulse
    logic             step_next;
    logic             dump_req_next;

    always_comb begin
        mode_next      = mode_q;
        ret_debug_next = ret_debug_q;
        step_next      = 1'b0;
        dump_req_next  = 1'b0;
        case (mode_q)
            debug_pkg::MODE_IDLE: begin
                if (i_rx_done) begin
                    if (i_rx == debug_pkg::CMD_LOAD) begin
                        mode_next = debug_pkg::MODE_LOAD;
                    end else if (i_rx == debug_pkg::CMD_DEBUG) begin
                        mode_next = debug_pkg::MODE_DEBUG;
                    end else if (i_rx == debug_pkg::CMD_CONTINUOUS) begin
                        mode_next = debug_pkg::MODE_CONTINUOUS;
                    end
                end
            end
            debug_pkg::MODE_LOAD: begin
                if (i_halt_seen) begin
                    mode_next = debug_pkg::MODE_IDLE;            // Program is in memory
                end
            end
            debug_pkg::MODE_DEBUG: begin
                if (i_rx_done) begin
                    if (i_rx == debug_pkg::CMD_STEP) begin
                        step_next      = 1'b1;
                        dump_req_next  = 1'b1;
                        ret_debug_next = 1'b1;
                        mode_next      = debug_pkg::MODE_DUMP;
                    end else if (i_rx == debug_pkg::CMD_END_DEBUG) begin
                        dump_req_next  = 1'b1;                   // Final dump without a step
                        ret_debug_next = 1'b0;
                        mode_next      = debug_pkg::MODE_DUMP;
                    end
                end
            end
            debug_pkg::MODE_CONTINUOUS: begin
                if (i_end) begin
                    dump_req_next  = 1'b1;
                    ret_debug_next = 1'b0;
                    mode_next      = debug_pkg::MODE_DUMP;
                end
            end
            debug_pkg::MODE_DUMP: begin
                if (i_dump_done) begin
                    mode_next = ret_debug_q ? debug_pkg::MODE_DEBUG : debug_pkg::MODE_IDLE;
                end
            end
            default: begin
                mode_next = debug_pkg::MODE_IDLE;                // Unused encodings recover
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q      <= debug_pkg::MODE_IDLE;
            ret_debug_q <= 1'b0;
            step_q      <= 1'b0;
            o_dump_req  <= 1'b0;
        end else begin
            mode_q      <= mode_next;
            ret_debug_q <= ret_debug_next;
            step_q      <= step_next;
            o_dump_req  <= dump_req_next;
        end
    end

    assign o_load_en = (mode_q == debug_pkg::MODE_LOAD);
    assign o_step    = (mode_q == debug_pkg::MODE_CONTINUOUS) || step_q;  // Held or pulsed
    assign o_start   = mode_q inside {debug_pkg::MODE_DEBUG, debug_pkg::MODE_CONTINUOUS,
                                      debug_pkg::MODE_DUMP};

endmodule

/* design/debug_pkg.sv */
package debug_pkg;

    // Link and word widths
    localparam int NB_BYTE    = 8;
    localparam int NB_WORD    = 32;
    localparam int WORD_BYTES = NB_WORD / NB_BYTE;               // Bytes per instruction word

    // Pipeline segment widths
    localparam int NB_ID_EX   = 144;
    localparam int NB_EX_MEM  = 32;
    localparam int NB_MEM_WB  = 48;
    localparam int NB_WB_ID   = 40;
    localparam int NB_CONTROL = 24;                              // ID/EX control register

    // Dump layout with ID/EX first and the control register last
    localparam int NB_DUMP     = NB_ID_EX + NB_EX_MEM + NB_MEM_WB + NB_WB_ID + NB_CONTROL;
    localparam int DUMP_BYTES  = NB_DUMP / NB_BYTE;              // 36 bytes per dump
    localparam int NB_DUMP_CNT = $clog2(DUMP_BYTES + 1);         // Counts 0 up to DUMP_BYTES

    typedef logic [NB_BYTE-1:0]     byte_t;
    typedef logic [NB_WORD-1:0]     word_t;
    typedef logic [NB_DUMP-1:0]     dump_t;
    typedef logic [NB_DUMP_CNT-1:0] dump_cnt_t;

    // Program load constants
    localparam word_t INSTR_STEP = 32'd4;                        // Byte address step per word
    localparam word_t HALT_INSTR = 32'hffffffff;                 // Last word of a program

    // Host command bytes
    localparam byte_t CMD_LOAD       = 8'h01;
    localparam byte_t CMD_DEBUG      = 8'h02;
    localparam byte_t CMD_CONTINUOUS = 8'h04;
    localparam byte_t CMD_STEP       = 8'h08;
    localparam byte_t CMD_END_DEBUG  = 8'h10;

    // Controller modes
    typedef enum logic [2:0] {
        MODE_IDLE       = 3'd0,
        MODE_LOAD       = 3'd1,                                  // Bytes go to the loader
        MODE_DEBUG      = 3'd2,                                  // Waiting for step or end
        MODE_CONTINUOUS = 3'd3,                                  // Free running until i_end
        MODE_DUMP       = 3'd4                                   // Serializer is busy
    } mode_e;

endpackage

/* design/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  debug_pkg::byte_t                  i_rx,
    input  logic                              i_rx_done,
    input  logic                              i_tx_done,
    input  logic                              i_end,
    input  logic [debug_pkg::NB_ID_EX-1:0]    i_seg_id_ex,
    input  logic [debug_pkg::NB_EX_MEM-1:0]   i_seg_ex_mem,
    input  logic [debug_pkg::NB_MEM_WB-1:0]   i_seg_mem_wb,
    input  logic [debug_pkg::NB_WB_ID-1:0]    i_seg_wb_id,
    input  logic [debug_pkg::NB_CONTROL-1:0]  i_ctrl_id_ex,
    output logic                              o_tx_start,
    output debug_pkg::byte_t                  o_data,
    output debug_pkg::word_t                  o_instruction,
    output debug_pkg::word_t                  o_instruction_address,
    output logic                              o_valid,
    output logic                              o_step,
    output logic                              o_start
);

    debug_pkg::dump_t dump;
    logic             load_en;
    logic             halt_seen;
    logic             dump_req;
    logic             dump_done;

    assign dump = {i_seg_id_ex, i_seg_ex_mem, i_seg_mem_wb, i_seg_wb_id, i_ctrl_id_ex};

    debug_ctrl u_debug_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rx        (i_rx),
        .i_rx_done   (i_rx_done),
        .i_end       (i_end),
        .i_halt_seen (halt_seen),
        .i_dump_done (dump_done),
        .o_load_en   (load_en),
        .o_dump_req  (dump_req),
        .o_step      (o_step),
        .o_start     (o_start)
    );

    instr_loader u_instr_loader (
        .clk                   (clk),
        .i_rst_n               (i_rst_n),
        .i_load_en             (load_en),
        .i_rx                  (i_rx),
        .i_rx_done             (i_rx_done),
        .o_instruction         (o_instruction),
        .o_instruction_address (o_instruction_address),
        .o_valid               (o_valid),
        .o_halt_seen           (halt_seen)
    );

    dump_serializer u_dump_serializer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_dump_req  (dump_req),
        .i_dump      (dump),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_data      (o_data),
        .o_dump_done (dump_done)
    );

endmodule

/* design/dump_serializer.sv */
`timescale 1ns/1ps

module dump_serializer (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_dump_req,
    input  debug_pkg::dump_t i_dump,
    input  logic             i_tx_done,
    output logic             o_tx_start,
    output debug_pkg::byte_t o_data,
    output logic             o_dump_done
);

    debug_pkg::dump_t     snap_q;                                // Frozen pipeline state
    debug_pkg::dump_cnt_t sent_cnt;                              // Bytes handed to the transmitter
    logic                 busy;                                  // Waiting on the transmitter
    logic                 last_byte;
    logic                 next_byte;

    assign last_byte = (sent_cnt == debug_pkg::dump_cnt_t'(debug_pkg::DUMP_BYTES));
    assign next_byte = busy && i_tx_done && !last_byte;

    // Snapshot and outgoing byte
    always_ff @(posedge clk) begin
        if (i_dump_req) begin
            snap_q <= i_dump;
            o_data <= i_dump[debug_pkg::NB_DUMP-1 -: debug_pkg::NB_BYTE];  // Most significant byte first
        end else if (next_byte) begin
            snap_q <= snap_q << debug_pkg::NB_BYTE;
            o_data <= snap_q[debug_pkg::NB_DUMP-debug_pkg::NB_BYTE-1 -: debug_pkg::NB_BYTE];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy        <= 1'b0;
            sent_cnt    <= '0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
            if (i_dump_req) begin
                busy       <= 1'b1;
                sent_cnt   <= debug_pkg::dump_cnt_t'(1);
                o_tx_start <= 1'b1;                              // First byte right away
            end else if (busy && i_tx_done) begin
                if (last_byte) begin
                    busy        <= 1'b0;
                    o_dump_done <= 1'b1;                         // Whole dump is out
                end else begin
                    sent_cnt   <= sent_cnt + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/instr_loader.sv */
`timescale 1ns/1ps

module instr_loader (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_load_en,
    input  debug_pkg::byte_t i_rx,
    input  logic             i_rx_done,
    output debug_pkg::word_t o_instruction,
    output debug_pkg::word_t o_instruction_address,
    output logic             o_valid,
    output logic             o_halt_seen
);

    debug_pkg::word_t shift_q;
    debug_pkg::word_t shift_next;
    debug_pkg::word_t addr_q;
    logic [1:0]       byte_cnt;
    logic             take_byte;
    logic             word_done;

    assign take_byte  = i_load_en && i_rx_done;
    assign word_done  = take_byte && (byte_cnt == 2'(debug_pkg::WORD_BYTES - 1));
    assign shift_next = {shift_q[debug_pkg::NB_WORD-debug_pkg::NB_BYTE-1:0], i_rx};  // First byte ends up on top

    // Instruction assembly
    always_ff @(posedge clk) begin
        if (take_byte) begin
            shift_q <= shift_next;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt    <= '0;
            addr_q      <= '0;
            o_valid     <= 1'b0;
            o_halt_seen <= 1'b0;
        end else begin
            o_valid     <= word_done;                            // Write strobe for a full word
            o_halt_seen <= word_done && (shift_next == debug_pkg::HALT_INSTR);
            if (!i_load_en) begin
                byte_cnt <= '0;                                  // Fresh start on every load
                addr_q   <= '0;
            end else begin
                if (take_byte) begin
                    byte_cnt <= byte_cnt + 2'd1;                 // Wraps after the fourth byte
                end
                if (o_valid) begin
                    addr_q <= addr_q + debug_pkg::INSTR_STEP;    // Next word slot
                end
            end
        end
    end

    assign o_instruction         = shift_q;
    assign o_instruction_address = addr_q;

endmodule

/* project.f */
design/debug_pkg.sv
design/instr_loader.sv
design/dump_serializer.sv
design/debug_ctrl.sv
design/debug_unit.sv
bench/debug_unit_assert.sv
bench/debug_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the debug unit testbench with Verilator and run it.
# Exit status is 0 only when the run reports no failure.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/debug_unit_sim

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module debug_unit_tb \
    -o debug_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
